//--- include/msix_defs.svh
// MSI-X controller sizing and AXI-lite address map constants
`ifndef MSIX_DEFS_SVH
`define MSIX_DEFS_SVH

// vector count and index width
`define MSIX_NUM_VEC        64
`define MSIX_INDEX_W        6
`define MSIX_TBL_WORDS      (2 * `MSIX_NUM_VEC)

// AXI-lite address map
`define MSIX_AXIL_ADDR_W    11
`define MSIX_PBA_SEL_BIT    10  // 0x400 and up is the PBA
`define MSIX_WORD_SEL_BIT   2   // upper half of a 64-bit word
`define MSIX_TBL_WADDR_LSB  3   // entry word address starts here

`endif

//--- source/msix_pkg.sv
// MSI-X table entry, bus write port and pending bit update types
`include "msix_defs.svh"

package msix_pkg;

    // even table word, message address
    typedef struct packed {
        logic [31:0] addr_hi;   // stored, never sent
        logic [29:0] addr_lo;
        logic [1:0]  rsvd;
    } msix_addr_view_t;

    // odd table word, message data and vector control
    typedef struct packed {
        logic [30:0] rsvd;
        logic        mask;
        logic [31:0] data;
    } msix_ctrl_view_t;

    typedef union packed {
        msix_addr_view_t addr;
        msix_ctrl_view_t ctrl;
    } msix_tbl_word_u;

    typedef struct packed {
        logic [`MSIX_INDEX_W:0] addr;   // {index, odd word}
        logic [7:0]             be;
        logic [63:0]            data;
    } msix_tbl_wr_t;

    typedef struct packed {
        logic                    set;
        logic                    clr;
        logic [`MSIX_INDEX_W-1:0] index;
    } msix_pba_upd_t;

endpackage

//--- source/tlp_pkg.sv
// PCIe memory-write TLP header and request types
`include "msix_defs.svh"

package tlp_pkg;

    localparam logic [2:0] TLP_FMT_3DW_DATA = 3'b010;
    localparam logic [4:0] TLP_TYPE_MEM     = 5'b00000;

    typedef struct packed {
        // DW0
        logic [2:0]  fmt;
        logic [4:0]  tlp_type;
        logic        rsvd0;     // T9
        logic [2:0]  tc;
        logic [3:0]  rsvd1;     // T8, attr[2], LN, TH
        logic        td;
        logic        ep;
        logic [1:0]  attr;
        logic [1:0]  rsvd2;     // AT
        logic [9:0]  length;
        // DW1
        logic [7:0]  req_bus;
        logic [7:0]  req_devfn;
        logic [7:0]  tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
        // DW2
        logic [29:0] addr;      // address[31:2]
        logic [1:0]  rsvd3;     // PH
    } tlp_mwr_hdr_t;

    typedef struct packed {
        tlp_mwr_hdr_t hdr;
        logic [31:0]  data;
    } tlp_mwr_req_t;

endpackage

//--- source/msix_axil_slave.sv
// AXI-lite slave for the MSI-X table and PBA, with read/write arbitration
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_axil_slave (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [`MSIX_AXIL_ADDR_W-1:0]  awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`MSIX_AXIL_ADDR_W-1:0]  araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,

    output logic                          tbl_wr_en,
    output msix_pkg::msix_tbl_wr_t        tbl_wr,
    output logic                          tbl_rd_en,
    output logic [`MSIX_INDEX_W:0]        tbl_rd_addr,
    input  logic [63:0]                   tbl_rd_data,
    input  logic [63:0]                   pba_word
);

    logic        last_read;
    logic        wr_elig;
    logic        rd_elig;
    logic        wr_go;
    logic        rd_go;
    logic        rd_pend;   // table data or PBA half ready for rdata
    logic        rd_move;
    logic        rd_pba;
    logic        rd_half;
    logic [31:0] pba_hold;
    logic [31:0] rd_sel;

    assign wr_elig = awvalid && wvalid && !awready && (!bvalid || bready);
    assign rd_elig = arvalid && !arready && (!rd_pend || !rvalid || rready);
    assign wr_go   = wr_elig && (!rd_elig || last_read);
    assign rd_go   = rd_elig && !wr_go;
    assign rd_move = rd_pend && (!rvalid || rready);

    // writes into the PBA region are dropped but still answered
    assign tbl_wr_en   = wr_go && !awaddr[`MSIX_PBA_SEL_BIT];
    assign tbl_wr.addr = awaddr[`MSIX_TBL_WADDR_LSB +: `MSIX_INDEX_W+1];
    assign tbl_wr.be   = awaddr[`MSIX_WORD_SEL_BIT] ? {wstrb, 4'h0} : {4'h0, wstrb};
    assign tbl_wr.data = {wdata, wdata};

    assign tbl_rd_en   = rd_go && !araddr[`MSIX_PBA_SEL_BIT];
    assign tbl_rd_addr = araddr[`MSIX_TBL_WADDR_LSB +: `MSIX_INDEX_W+1];

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_comb begin
        if (rd_pba) begin
            rd_sel = pba_hold;
        end else if (rd_half) begin
            rd_sel = tbl_rd_data[63:32];
        end else begin
            rd_sel = tbl_rd_data[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rd_pend   <= 1'b0;
            last_read <= 1'b0;
        end else begin
            awready <= wr_go;
            wready  <= wr_go;
            arready <= rd_go;
            if (wr_go) begin
                bvalid    <= 1'b1;
                last_read <= 1'b0;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) begin
                last_read <= 1'b1;
            end
            if (rd_move) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            rd_pend <= rd_go || (rd_pend && !rd_move);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rd_pba   <= araddr[`MSIX_PBA_SEL_BIT];
            rd_half  <= araddr[`MSIX_WORD_SEL_BIT];
            pba_hold <= araddr[`MSIX_WORD_SEL_BIT] ? pba_word[63:32] : pba_word[31:0];
        end
        if (rd_move) begin
            rdata <= rd_sel;    // held while rready is low
        end
    end

endmodule

//--- source/msix_vector_table.sv
// MSI-X vector table RAM with bus and engine read ports, plus the PBA register
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_vector_table (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           tbl_wr_en,
    input  msix_pkg::msix_tbl_wr_t         tbl_wr,
    input  logic                           tbl_rd_en,
    input  logic [`MSIX_INDEX_W:0]         tbl_rd_addr,
    output logic [63:0]                    tbl_rd_data,

    input  logic                           eng_rd_en,
    input  logic [`MSIX_INDEX_W:0]         eng_rd_addr,
    output msix_pkg::msix_tbl_word_u       eng_rd_data,

    input  msix_pkg::msix_pba_upd_t        pba_upd,
    output logic [`MSIX_NUM_VEC-1:0]       pba_word
);

    logic [63:0] mem [`MSIX_TBL_WORDS];

    // table starts out all zero, so every vector reads as unmasked
    initial begin
        for (int i = 0; i < `MSIX_TBL_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_wr_en) begin
            for (int b = 0; b < 8; b++) begin
                if (tbl_wr.be[b]) begin
                    mem[tbl_wr.addr][8*b +: 8] <= tbl_wr.data[8*b +: 8];
                end
            end
        end
        if (tbl_rd_en) begin
            tbl_rd_data <= mem[tbl_rd_addr];
        end
        if (eng_rd_en) begin
            eng_rd_data <= mem[eng_rd_addr];
        end
    end

    // pending bits, written only by the engine
    always_ff @(posedge clk) begin
        if (rst) begin
            pba_word <= '0;
        end else if (pba_upd.set) begin
            pba_word[pba_upd.index] <= 1'b1;
        end else if (pba_upd.clr) begin
            pba_word[pba_upd.index] <= 1'b0;
        end
    end

endmodule

//--- source/msix_irq_engine.sv
// MSI-X interrupt engine: request and PBA replay FSM, memory-write TLP output
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_irq_engine (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       irq_valid,
    output logic                       irq_ready,
    input  logic [`MSIX_INDEX_W-1:0]   irq_index,

    output logic                       eng_rd_en,
    output logic [`MSIX_INDEX_W:0]     eng_rd_addr,
    input  msix_pkg::msix_tbl_word_u   eng_rd_data,
    input  logic [`MSIX_NUM_VEC-1:0]   pba_word,
    output msix_pkg::msix_pba_upd_t    pba_upd,

    input  logic [7:0]                 bus_num,
    input  logic [7:0]                 func_num,
    input  logic                       msix_enable,
    input  logic                       msix_mask,

    output logic                       tlp_valid,
    input  logic                       tlp_ready,
    output tlp_pkg::tlp_mwr_req_t      tlp_req
);

    import tlp_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_CTRL,
        ST_SEND
    } state_t;

    state_t                   state;
    state_t                   state_next;
    logic [`MSIX_INDEX_W-1:0] idx;
    logic [`MSIX_INDEX_W-1:0] idx_next;
    logic [29:0]              vec_addr;
    logic [31:0]              vec_data;
    logic                     en_reg;
    logic                     mask_reg;
    logic                     scan_ok;
    logic                     tlp_busy;
    logic                     tlp_load;
    logic                     irq_ready_next;
    tlp_mwr_hdr_t             hdr;

    assign tlp_busy = tlp_valid && !tlp_ready;
    assign scan_ok  = !irq_valid && en_reg && !mask_reg;

    always_comb begin
        hdr           = '0;
        hdr.fmt       = TLP_FMT_3DW_DATA;
        hdr.tlp_type  = TLP_TYPE_MEM;
        hdr.length    = 10'd1;
        hdr.req_bus   = bus_num;
        hdr.req_devfn = func_num;
        hdr.first_be  = 4'b1111;
        hdr.addr      = vec_addr;
    end

    always_comb begin
        state_next     = state;
        idx_next       = idx;
        eng_rd_en      = 1'b0;
        eng_rd_addr    = {idx, 1'b0};
        pba_upd        = '0;
        pba_upd.index  = idx;
        irq_ready_next = 1'b0;
        tlp_load       = 1'b0;

        case (state)
            ST_IDLE: begin
                if (irq_valid && irq_ready) begin
                    idx_next    = irq_index;
                    eng_rd_en   = 1'b1;
                    eng_rd_addr = {irq_index, 1'b0};
                    state_next  = ST_RD_ADDR;
                end else begin
                    irq_ready_next = !tlp_busy;
                    if (scan_ok && pba_word[idx]) begin
                        irq_ready_next = 1'b0;  // replay this pending vector
                        eng_rd_en      = 1'b1;
                        state_next     = ST_RD_ADDR;
                    end else if (scan_ok && |pba_word) begin
                        idx_next = idx + 1'b1;
                    end
                end
            end
            ST_RD_ADDR: begin
                eng_rd_en   = 1'b1;
                eng_rd_addr = {idx, 1'b1};
                state_next  = ST_RD_CTRL;
            end
            ST_RD_CTRL: begin
                if (en_reg && !mask_reg && !eng_rd_data.ctrl.mask) begin
                    state_next = ST_SEND;
                end else begin
                    pba_upd.set    = 1'b1;
                    idx_next       = idx + 1'b1;    // let the scan move past it
                    irq_ready_next = !tlp_busy;
                    state_next     = ST_IDLE;
                end
            end
            ST_SEND: begin
                if (!tlp_busy) begin
                    tlp_load    = 1'b1;
                    pba_upd.clr = 1'b1;
                    idx_next    = idx + 1'b1;
                    state_next  = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            idx       <= '0;
            irq_ready <= 1'b0;
            tlp_valid <= 1'b0;
            en_reg    <= 1'b0;
            mask_reg  <= 1'b0;
        end else begin
            state     <= state_next;
            idx       <= idx_next;
            irq_ready <= irq_ready_next;
            tlp_valid <= tlp_load || tlp_busy;
            en_reg    <= msix_enable;
            mask_reg  <= msix_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_RD_ADDR) begin
            vec_addr <= eng_rd_data.addr.addr_lo;
        end
        if (state == ST_RD_CTRL) begin
            vec_data <= eng_rd_data.ctrl.data;
        end
        if (tlp_load) begin
            tlp_req.hdr  <= hdr;
            tlp_req.data <= vec_data;
        end
    end

endmodule

//--- source/msix_top.sv
// MSI-X interrupt controller top level
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_top (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [`MSIX_AXIL_ADDR_W-1:0]  awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`MSIX_AXIL_ADDR_W-1:0]  araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,

    input  logic                          irq_valid,
    output logic                          irq_ready,
    input  logic [`MSIX_INDEX_W-1:0]      irq_index,

    output logic                          tlp_valid,
    input  logic                          tlp_ready,
    output tlp_pkg::tlp_mwr_req_t         tlp_req,

    input  logic [7:0]                    bus_num,
    input  logic [7:0]                    func_num,
    input  logic                          msix_enable,
    input  logic                          msix_mask
);

    import msix_pkg::*;

    logic                     tbl_wr_en;
    msix_tbl_wr_t             tbl_wr;
    logic                     tbl_rd_en;
    logic [`MSIX_INDEX_W:0]   tbl_rd_addr;
    logic [63:0]              tbl_rd_data;
    logic [`MSIX_NUM_VEC-1:0] pba_word;
    logic                     eng_rd_en;
    logic [`MSIX_INDEX_W:0]   eng_rd_addr;
    msix_tbl_word_u           eng_rd_data;
    msix_pba_upd_t            pba_upd;

    msix_axil_slave u_axil (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .tbl_wr_en, .tbl_wr, .tbl_rd_en, .tbl_rd_addr, .tbl_rd_data,
        .pba_word
    );

    msix_vector_table u_table (
        .clk, .rst,
        .tbl_wr_en, .tbl_wr, .tbl_rd_en, .tbl_rd_addr, .tbl_rd_data,
        .eng_rd_en, .eng_rd_addr, .eng_rd_data,
        .pba_upd, .pba_word
    );

    msix_irq_engine u_engine (
        .clk, .rst,
        .irq_valid, .irq_ready, .irq_index,
        .eng_rd_en, .eng_rd_addr, .eng_rd_data, .pba_word, .pba_upd,
        .bus_num, .func_num, .msix_enable, .msix_mask,
        .tlp_valid, .tlp_ready, .tlp_req
    );

endmodule

//--- dv/msix_assert.sv
// Handshake stability checks on the MSI-X controller ports, bound into the top level
`timescale 1ns/1ps

module msix_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  tlp_valid,
    input logic                  tlp_ready,
    input tlp_pkg::tlp_mwr_req_t tlp_req,
    input logic                  rvalid,
    input logic                  rready,
    input logic [31:0]           rdata,
    input logic                  bvalid,
    input logic                  bready,
    input logic                  irq_ready
);

    tlp_hold: assert property (@(posedge clk) disable iff (rst)
        tlp_valid && !tlp_ready |=> tlp_valid && $stable(tlp_req))
        else $error("tlp_valid or tlp_req changed before tlp_ready");

    rdata_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // no new request taken while a TLP waits
    irq_block: assert property (@(posedge clk) disable iff (rst)
        tlp_valid && !tlp_ready |-> !irq_ready)
        else $error("irq_ready high while the TLP output is stalled");

endmodule

bind msix_top msix_assert u_assert (.*);

//--- dv/tb_msix.sv
// Testbench for the MSI-X controller covering table access, delivery, masking and back-pressure
`timescale 1ns/1ps
`include "msix_defs.svh"

module tb_msix;

    import tlp_pkg::*;

    localparam int T1_N  = 40;  // write plus read each
    localparam int T2_N  = 8;   // three writes, request, TLP
    localparam int T3_TX = 12;
    localparam int T4_N  = 6;
    localparam int T5_N  = 10;
    localparam int TXN_TOTAL  = 2 * T1_N + 5 * T2_N + T3_TX + 5 * T4_N + 4 + 6 * T5_N;
    localparam int MAX_CYCLES = TXN_TOTAL * 40;
    localparam int DRAIN      = 40;

    logic                         clk;
    logic                         rst;
    logic [`MSIX_AXIL_ADDR_W-1:0] awaddr;
    logic                         awvalid;
    logic                         awready;
    logic [31:0]                  wdata;
    logic [3:0]                   wstrb;
    logic                         wvalid;
    logic                         wready;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;
    logic [`MSIX_AXIL_ADDR_W-1:0] araddr;
    logic                         arvalid;
    logic                         arready;
    logic [31:0]                  rdata;
    logic [1:0]                   rresp;
    logic                         rvalid;
    logic                         rready;
    logic                         irq_valid;
    logic                         irq_ready;
    logic [`MSIX_INDEX_W-1:0]     irq_index;
    logic                         tlp_valid;
    logic                         tlp_ready;
    tlp_mwr_req_t                 tlp_req;
    logic [7:0]                   bus_num;
    logic [7:0]                   func_num;
    logic                         msix_enable;
    logic                         msix_mask;

    // reference model
    logic [63:0]  shadow [`MSIX_TBL_WORDS];
    logic [63:0]  pend;
    tlp_mwr_req_t exp_q[$];
    tlp_mwr_req_t rcv_q[$];

    logic [31:0] lfsr;
    logic        bp_on;
    int          cycles;
    int          errors;
    string       test_name;

    msix_top uut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            report_failure();
        end
    end

    // mid-cycle TLP monitor
    always @(negedge clk) begin
        if (!rst && tlp_valid && tlp_ready) begin
            rcv_q.push_back(tlp_req);
        end
    end

    task automatic report_failure();
        errors++;
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    task automatic check32(input string what, input logic [31:0] want, input logic [31:0] got);
        assert (got === want) else begin
            $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, want, got);
            report_failure();
        end
    endtask

    // one clock, then drive inputs 1 ns later
    task automatic tick();
        @(posedge clk);
        #1;
        if (bp_on) begin
            tlp_ready = rand_bit();
        end else begin
            tlp_ready = 1'b1;
        end
    endtask

    task automatic axil_write(input logic [10:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [6:0] w;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        tick();
        while (!awready) begin
            tick();
        end
        check32("write data ready", 32'd1, {31'd0, wready});
        check32("write response", 32'h4, {29'd0, bvalid, bresp});  // bvalid with OKAY
        tick();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = rand_bit();   // random response stalls
        while (!(bvalid && bready)) begin
            tick();
            bready = rand_bit();
        end
        tick();
        bready = 1'b0;
        if (!addr[`MSIX_PBA_SEL_BIT]) begin
            w = addr[9:3];
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[w][32 * addr[2] + 8 * b +: 8] = data[8 * b +: 8];
                end
            end
        end
    endtask

    task automatic axil_read(input logic [10:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        tick();
        while (!arready) begin
            tick();
        end
        tick();
        arvalid = 1'b0;
        rready  = rand_bit();   // random read stalls
        while (!(rvalid && rready)) begin
            tick();
            rready = rand_bit();
        end
        data = rdata;
        check32("read response", 32'd0, {30'd0, rresp});
        tick();
        rready = 1'b0;
    endtask

    task automatic check_pba();
        logic [31:0] got;
        axil_read(11'h400, got);
        check32("pba low word", pend[31:0], got);
        axil_read(11'h404, got);
        check32("pba high word", pend[63:32], got);
    endtask

    // address low, data, control dwords of one entry
    task automatic setup_vector(input logic [5:0] idx, input logic masked);
        logic [10:0] base;
        base = {1'b0, idx, 4'h0};
        axil_write(base, rand_bits(32), 4'hf);
        axil_write(base + 11'd8, rand_bits(32), 4'hf);
        axil_write(base + 11'd12, {31'd0, masked}, 4'hf);
    endtask

    task automatic send_irq(input logic [5:0] idx);
        irq_index = idx;
        irq_valid = 1'b1;
        while (!irq_ready) begin
            tick();
        end
        tick();
        irq_valid = 1'b0;
    endtask

    // irq_ready comes back once the request is sent or pended
    task automatic wait_resolved();
        tick();
        while (!irq_ready) begin
            tick();
        end
    endtask

    task automatic wait_tlps(input int n);
        while (rcv_q.size() < n) begin
            tick();
        end
    endtask

    function automatic tlp_mwr_req_t expect_tlp(input logic [5:0] idx);
        tlp_mwr_req_t t;
        logic [63:0]  a;
        logic [63:0]  c;
        a = shadow[{idx, 1'b0}];
        c = shadow[{idx, 1'b1}];
        t = '0;
        t.hdr.fmt       = 3'b010;   // 3DW, with data
        t.hdr.tlp_type  = 5'b00000; // memory request
        t.hdr.length    = 10'd1;
        t.hdr.req_bus   = bus_num;
        t.hdr.req_devfn = func_num;
        t.hdr.first_be  = 4'hf;
        t.hdr.addr      = a[31:2];
        t.data          = c[31:0];
        return t;
    endfunction

    task automatic check_tlps(input logic as_set);
        int hit;
        assert (rcv_q.size() == exp_q.size()) else begin
            $display("** Error [%s] TLP count: expected %0d, actual %0d",
                     test_name, exp_q.size(), rcv_q.size());
            report_failure();
        end
        foreach (rcv_q[i]) begin
            if (as_set) begin
                hit = -1;
                foreach (exp_q[j]) begin
                    if (hit < 0 && exp_q[j] == rcv_q[i]) begin
                        hit = j;
                    end
                end
                assert (hit >= 0) else begin
                    $display("** Error [%s] TLP not expected: expected %0h, actual %0h",
                             test_name, exp_q[0], rcv_q[i]);
                    report_failure();
                end
                exp_q.delete(hit);
            end else begin
                assert (rcv_q[i] == exp_q[i]) else begin
                    $display("** Error [%s] TLP %0d: expected %0h, actual %0h",
                             test_name, i, exp_q[i], rcv_q[i]);
                    report_failure();
                end
            end
        end
        rcv_q.delete();
        exp_q.delete();
    endtask

    task automatic test_table_access();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] got;
        logic [31:0] want;
        logic [10:0] addr;
        test_name = "table_access";
        for (int i = 0; i < T1_N; i++) begin
            r    = rand_bits(9);
            addr = {r[8:0], 2'b00};    // bit 10 picks the PBA about half the time
            data = rand_bits(32);
            r    = rand_bits(4);
            axil_write(addr, data, r[3:0]);
            axil_read(addr, got);
            if (addr[`MSIX_PBA_SEL_BIT]) begin
                want = addr[2] ? pend[63:32] : pend[31:0];
            end else begin
                want = addr[2] ? shadow[addr[9:3]][63:32] : shadow[addr[9:3]][31:0];
            end
            check32("readback", want, got);
        end
    endtask

    task automatic test_unmasked_delivery();
        logic [31:0] r;
        test_name   = "unmasked_delivery";
        msix_enable = 1'b1;
        msix_mask   = 1'b0;
        for (int i = 0; i < T2_N; i++) begin
            r = rand_bits(6);
            setup_vector(r[5:0], 1'b0);
            exp_q.push_back(expect_tlp(r[5:0]));
            send_irq(r[5:0]);
        end
        wait_tlps(T2_N);
        repeat (DRAIN) tick();
        check_tlps(1'b0);
    endtask

    task automatic test_masked_vector();
        logic [31:0] r;
        logic [5:0]  idx;
        test_name = "masked_vector";
        r   = rand_bits(6);
        idx = r[5:0];
        setup_vector(idx, 1'b1);
        send_irq(idx);
        wait_resolved();
        pend[idx] = 1'b1;
        check_pba();
        check32("TLPs while masked", 32'd0, rcv_q.size());
        axil_write({1'b0, idx, 4'hc}, 32'd0, 4'hf);    // clear vector mask
        exp_q.push_back(expect_tlp(idx));
        pend[idx] = 1'b0;
        wait_tlps(1);
        repeat (DRAIN) tick();
        check_tlps(1'b1);
        check_pba();
    endtask

    task automatic test_function_control();
        logic [31:0] r;
        test_name   = "function_control";
        msix_enable = 1'b0;
        msix_mask   = 1'b0;
        for (int i = 0; i < T4_N; i++) begin
            if (i == T4_N / 2) begin
                msix_enable = 1'b1;
                msix_mask   = 1'b1;
            end
            r = rand_bits(6);
            setup_vector(r[5:0], 1'b0);
            send_irq(r[5:0]);
            pend[r[5:0]] = 1'b1;
        end
        wait_resolved();
        check_pba();
        check32("TLPs while blocked", 32'd0, rcv_q.size());
        for (int v = 0; v < `MSIX_NUM_VEC; v++) begin
            if (pend[v]) begin
                exp_q.push_back(expect_tlp(v[5:0]));
            end
        end
        pend      = '0;
        msix_mask = 1'b0;
        wait_tlps(exp_q.size());
        repeat (DRAIN) tick();
        check_tlps(1'b1);   // scan order differs from request order
        check_pba();
    endtask

    task automatic test_back_pressure();
        logic [31:0] r;
        test_name = "back_pressure";
        bp_on     = 1'b1;
        for (int i = 0; i < T5_N; i++) begin
            r = rand_bits(6);
            setup_vector(r[5:0], 1'b0);
            exp_q.push_back(expect_tlp(r[5:0]));
            send_irq(r[5:0]);
        end
        wait_tlps(T5_N);
        bp_on = 1'b0;
        repeat (DRAIN) tick();
        check_tlps(1'b0);
    endtask

    initial begin
        logic [31:0] r;
        lfsr        = 32'h1bc;
        cycles      = 0;
        errors      = 0;
        bp_on       = 1'b0;
        pend        = '0;
        rst         = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        irq_valid   = 1'b0;
        irq_index   = '0;
        tlp_ready   = 1'b1;
        msix_enable = 1'b0;
        msix_mask   = 1'b0;
        r           = rand_bits(16);
        bus_num     = r[15:8];
        func_num    = r[7:0];
        for (int i = 0; i < `MSIX_TBL_WORDS; i++) begin
            shadow[i] = '0;
        end

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();

        test_table_access();
        test_unmasked_delivery();
        test_masked_vector();
        test_function_control();
        test_back_pressure();

        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
source/msix_pkg.sv
source/tlp_pkg.sv
source/msix_axil_slave.sv
source/msix_vector_table.sv
source/msix_irq_engine.sv
source/msix_top.sv
dv/msix_assert.sv
dv/tb_msix.sv

//--- Bender.yml
package:
  name: msix_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/msix_pkg.sv
      - source/tlp_pkg.sv
      - source/msix_axil_slave.sv
      - source/msix_vector_table.sv
      - source/msix_irq_engine.sv
      - source/msix_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/msix_assert.sv
      - dv/tb_msix.sv
